//--- mk14_vdu_pkg.sv
package mk14_vdu_pkg;

	// bus and memory widths
	typedef logic [15:0] addr_t;	// host bus address
	typedef logic [7:0] byte_t;	// data byte
	typedef logic [7:0] vaddr_t;	// offset into display RAM

	// host port FSM
	typedef enum logic [1:0] {
		HS_IDLE,	// no access pending
		HS_WAIT,	// request raised, waiting for grant
		HS_DATA	// read data returning from RAM
	} host_state_t;

	// display window on the host bus
	localparam addr_t VDU_BASE_ADDR = 16'h0200;
	localparam int DISP_BYTES = 256;
	localparam int BYTES_PER_LINE = 8;

	// horizontal timing in pixels
	localparam int H_ACTIVE = 64;
	localparam int H_FRONT = 4;
	localparam int H_SYNC = 8;
	localparam int H_TOTAL = 80;	// back porch is what is left

	// vertical timing in lines
	localparam int V_ACTIVE = 32;
	localparam int V_FRONT = 2;
	localparam int V_SYNC = 2;
	localparam int V_TOTAL = 40;

endpackage

//--- disp_ram.sv
`timescale 1ns/10ps

module disp_ram
	import mk14_vdu_pkg::*;
(
	input wire logic clk,
	input wire logic ram_en,
	input wire logic ram_we,
	input wire vaddr_t ram_addr,
	input wire byte_t ram_wdata,
	output byte_t ram_rdata
);

byte_t mem [DISP_BYTES];	// display bytes, eight per raster line

// one port, read returns the old contents on a write
always_ff @(posedge clk) begin
	if (ram_en) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_wdata;
		end
		ram_rdata <= mem[ram_addr];	// valid the cycle after enable
	end
end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter
	import mk14_vdu_pkg::*;
(
	// scanner side
	input wire logic vdu_req,
	input wire vaddr_t vdu_addr,
	output byte_t vdu_rdata,

	// host side
	input wire logic host_req,
	input wire logic host_we,
	input wire vaddr_t host_addr,
	input wire byte_t host_wdata,
	output logic host_gnt,
	output byte_t host_rdata,

	// RAM port
	input wire byte_t ram_rdata,
	output logic ram_en,
	output logic ram_we,
	output vaddr_t ram_addr,
	output byte_t ram_wdata
);

// scanner always wins, host holds its request until a free cycle
assign host_gnt = host_req & ~vdu_req;

always_comb begin
	ram_en = vdu_req | host_req;
	ram_we = host_gnt & host_we;	// scanner only ever reads
	ram_addr = vdu_req ? vdu_addr : host_addr;
	ram_wdata = host_wdata;
end

// both see the same read data, each one knows when its byte is due
assign vdu_rdata = ram_rdata;
assign host_rdata = ram_rdata;

endmodule

//--- host_port.sv
`timescale 1ns/10ps

module host_port
	import mk14_vdu_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,

	// host bus
	input wire addr_t bus_addr,
	input wire byte_t bus_wdata,
	input wire logic bus_wr,
	input wire logic bus_rd,
	output byte_t bus_rdata,
	output logic bus_rdata_valid,
	output logic bus_busy,

	// to arbiter
	input wire logic host_gnt,
	input wire byte_t host_rdata,
	output logic host_req,
	output logic host_we,
	output vaddr_t host_addr,
	output byte_t host_wdata
);

host_state_t state;
addr_t offset;
logic in_window;
logic accept;

// window decode, addresses below the base wrap to large offsets
assign offset = bus_addr - VDU_BASE_ADDR;
assign in_window = offset < addr_t'(DISP_BYTES);
assign accept = (state == HS_IDLE) && (bus_wr || bus_rd) && in_window;

assign bus_busy = (state != HS_IDLE);
assign host_req = (state == HS_WAIT);

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state <= HS_IDLE;
		bus_rdata_valid <= 1'b0;
	end else begin
		bus_rdata_valid <= 1'b0;
		case (state)
			HS_IDLE: if (accept) state <= HS_WAIT;
			HS_WAIT: if (host_gnt) state <= host_we ? HS_IDLE : HS_DATA;
			HS_DATA: begin
				state <= HS_IDLE;
				bus_rdata_valid <= 1'b1;	// lines up with busy falling
			end
			default: state <= HS_IDLE;
		endcase
	end
end

// access payload and returned byte
always_ff @(posedge clk) begin
	if (accept) begin
		host_we <= bus_wr;	// write wins if both strobes are set
		host_addr <= vaddr_t'(offset);
		host_wdata <= bus_wdata;
	end
	if (state == HS_DATA) begin
		bus_rdata <= host_rdata;	// RAM output one cycle after grant
	end
end

endmodule

//--- vdu_scanner.sv
`timescale 1ns/10ps

module vdu_scanner
	import mk14_vdu_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,

	// display RAM fetch
	input wire byte_t vdu_rdata,
	output logic vdu_req,
	output vaddr_t vdu_addr,

	// video out
	output logic vga_hsync,	// active low
	output logic vga_vsync,	// active low
	output logic vga_de,
	output logic [4:0] vga_r,
	output logic [5:0] vga_g,
	output logic [4:0] vga_b
);

logic [6:0] h_cnt;	// pixel in line
logic [5:0] v_cnt;	// line in frame
logic h_last;
logic v_last;
logic pix_act;
logic pre_line;	// last byte slot of a line, fetches next line
logic [5:0] fetch_line;
logic [2:0] fetch_col;
logic rd_due;
logic primed;
logic shift_load;
logic lit;
byte_t hold_byte;
byte_t shifter;
byte_t shift_next;

assign h_last = (h_cnt == 7'(H_TOTAL - 1));
assign v_last = (v_cnt == 6'(V_TOTAL - 1));
assign pix_act = (h_cnt < 7'(H_ACTIVE)) && (v_cnt < 6'(V_ACTIVE));

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		h_cnt <= '0;
		v_cnt <= '0;
	end else if (h_last) begin
		h_cnt <= '0;
		v_cnt <= v_last ? '0 : v_cnt + 6'd1;
	end else begin
		h_cnt <= h_cnt + 7'd1;
	end
end

// byte for column 8k is fetched eight pixels ahead of it
assign pre_line = (h_cnt == 7'(H_TOTAL - BYTES_PER_LINE));

always_comb begin
	if (pre_line) begin
		fetch_line = v_last ? '0 : v_cnt + 6'd1;
		fetch_col = '0;
	end else begin
		fetch_line = v_cnt;
		fetch_col = h_cnt[5:3] + 3'd1;
	end
	vdu_req = (fetch_line < 6'(V_ACTIVE)) &&
		(pre_line || (h_cnt[2:0] == 3'd0 && h_cnt < 7'(H_ACTIVE - BYTES_PER_LINE)));
	vdu_addr = vaddr_t'(int'(fetch_line) * BYTES_PER_LINE + int'(fetch_col));
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		rd_due <= 1'b0;
		primed <= 1'b0;
	end else begin
		rd_due <= vdu_req;	// RAM answers next cycle
		if (vdu_req && pre_line && v_last) begin
			primed <= 1'b1;	// line 0 column 0 now on its way
		end
	end
end

// reload at every byte boundary of the active area, else shift left
assign shift_load = pix_act && (h_cnt[2:0] == 3'd0);
assign shift_next = shift_load ? hold_byte : {shifter[6:0], 1'b0};
assign lit = pix_act && primed && shift_next[7];

always_ff @(posedge clk) begin
	if (rd_due) begin
		hold_byte <= vdu_rdata;
	end
	shifter <= shift_next;
end

// registered video, syncs after the front porches
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		vga_hsync <= 1'b1;
		vga_vsync <= 1'b1;
		vga_de <= 1'b0;
		vga_r <= '0;
		vga_g <= '0;
		vga_b <= '0;
	end else begin
		vga_hsync <= !((h_cnt >= 7'(H_ACTIVE + H_FRONT)) &&
			(h_cnt < 7'(H_ACTIVE + H_FRONT + H_SYNC)));
		vga_vsync <= !((v_cnt >= 6'(V_ACTIVE + V_FRONT)) &&
			(v_cnt < 6'(V_ACTIVE + V_FRONT + V_SYNC)));
		vga_de <= pix_act;
		vga_r <= {5{lit}};	// lit pixel is white
		vga_g <= {6{lit}};
		vga_b <= {5{lit}};
	end
end

endmodule

//--- mk14_display.sv
`timescale 1ns/10ps

module mk14_display
	import mk14_vdu_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,

	// host bus
	input wire addr_t bus_addr,
	input wire byte_t bus_wdata,
	input wire logic bus_wr,
	input wire logic bus_rd,
	output byte_t bus_rdata,
	output logic bus_rdata_valid,
	output logic bus_busy,

	// video
	output logic vga_hsync,
	output logic vga_vsync,
	output logic vga_de,
	output logic [4:0] vga_r,
	output logic [5:0] vga_g,
	output logic [4:0] vga_b
);

// host side of the arbiter
logic host_req;
logic host_we;
vaddr_t host_addr;
byte_t host_wdata;
logic host_gnt;
byte_t host_rdata;

// scanner side of the arbiter
logic vdu_req;
vaddr_t vdu_addr;
byte_t vdu_rdata;

// shared RAM port
logic ram_en;
logic ram_we;
vaddr_t ram_addr;
byte_t ram_wdata;
byte_t ram_rdata;

host_port u_host_port (
	.clk,
	.rst_n,
	.bus_addr,
	.bus_wdata,
	.bus_wr,
	.bus_rd,
	.bus_rdata,
	.bus_rdata_valid,
	.bus_busy,
	.host_gnt,
	.host_rdata,
	.host_req,
	.host_we,
	.host_addr,
	.host_wdata
);

vdu_scanner u_vdu_scanner (
	.clk,
	.rst_n,
	.vdu_rdata,
	.vdu_req,
	.vdu_addr,
	.vga_hsync,
	.vga_vsync,
	.vga_de,
	.vga_r,
	.vga_g,
	.vga_b
);

mem_arbiter u_mem_arbiter (
	.vdu_req,
	.vdu_addr,
	.vdu_rdata,
	.host_req,
	.host_we,
	.host_addr,
	.host_wdata,
	.host_gnt,
	.host_rdata,
	.ram_rdata,
	.ram_en,
	.ram_we,
	.ram_addr,
	.ram_wdata
);

disp_ram u_disp_ram (
	.clk,
	.ram_en,
	.ram_we,
	.ram_addr,
	.ram_wdata,
	.ram_rdata
);

endmodule

//--- tb_mk14_display.sv
`timescale 1ns/10ps

module tb_mk14_display
	import mk14_vdu_pkg::*;
();

localparam int STIM_WORDS = 256;	// four words per operation
localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

logic clk;
logic rst_n;
addr_t bus_addr;
byte_t bus_wdata;
logic bus_wr;
logic bus_rd;
byte_t bus_rdata;
logic bus_rdata_valid;
logic bus_busy;
logic vga_hsync;
logic vga_vsync;
logic vga_de;
logic [4:0] vga_r;
logic [5:0] vga_g;
logic [4:0] vga_b;

logic [15:0] stim_mem [STIM_WORDS];
byte_t model [DISP_BYTES];	// expected display RAM contents
logic [31:0] lfsr;
int err_data;
int err_bus;
int err_pix;
int err_sync;
int cycle_limit;
int frame_cnt;
logic check_pix;
logic prev_hs;
logic prev_vs;
int hs_run;
int hs_pulses;
int vs_low;
int de_cnt;
int px_x;
int px_y;

mk14_display u_mk14_display (
	.clk,
	.rst_n,
	.bus_addr,
	.bus_wdata,
	.bus_wr,
	.bus_rd,
	.bus_rdata,
	.bus_rdata_valid,
	.bus_busy,
	.vga_hsync,
	.vga_vsync,
	.vga_de,
	.vga_r,
	.vga_g,
	.vga_b
);

always #4 clk = ~clk;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
endfunction

task automatic take_bits(input int n, output int v);
	v = 0;
	for (int i = 0; i < n; i++) begin
		v = (v << 1) | int'(lfsr[0]);
		lfsr = lfsr_next(lfsr);
	end
endtask

function automatic logic in_window(input addr_t a);
	return (a >= VDU_BASE_ADDR) && (a <= VDU_BASE_ADDR + 16'(DISP_BYTES - 1));
endfunction

function automatic byte_t fill_byte(input addr_t a, input byte_t seed);
	return byte_t'(a[7:0] * 8'd29) ^ a[15:8] ^ seed;	// odd multiplier keeps bytes distinct
endfunction

// one host strobe after a random gap and its outcome
task automatic bus_access(input logic wr, input addr_t a, input byte_t d, input byte_t exp);
	int gap;
	int n;
	take_bits(4, gap);
	repeat (gap) @(negedge clk);
	n = 0;
	while (bus_busy && n < 32) begin
		@(negedge clk);
		n++;
	end
	bus_addr = a;
	bus_wdata = d;
	bus_wr = wr;
	bus_rd = !wr;
	@(negedge clk);
	bus_wr = 1'b0;
	bus_rd = 1'b0;
	if (!in_window(a)) begin
		for (int i = 0; i < 4; i++) begin
			assert (!bus_busy && !bus_rdata_valid) else begin
				err_bus++;
				$display("access to %h outside the window started a bus cycle", a);
			end
			@(negedge clk);
		end
	end else if (wr) begin
		model[a[7:0]] = d;
		n = 0;
		while (bus_busy && n < 16) begin
			@(negedge clk);
			n++;
		end
		assert (!bus_busy) else begin
			err_bus++;
			$display("write to %h never released bus_busy", a);
		end
	end else begin
		n = 0;
		while (!bus_rdata_valid && n < 16) begin
			@(negedge clk);
			n++;
		end
		assert (bus_rdata_valid) else begin
			err_bus++;
			$display("read from %h never returned data", a);
		end
		if (bus_rdata_valid) begin
			assert (bus_rdata == exp) else begin
				err_data++;
				$display("CHECK FAILED bus_rdata at %h: got %h expected %h", a, bus_rdata, exp);
			end
		end
	end
endtask

task automatic fill_window(input byte_t seed);
	addr_t a;
	for (int i = 0; i < DISP_BYTES; i++) begin
		a = VDU_BASE_ADDR + addr_t'(i);
		bus_access(1'b1, a, fill_byte(a, seed), 8'h00);
	end
endtask

task automatic wait_frames(input int n);
	int f0;
	f0 = frame_cnt;
	while (frame_cnt < f0 + 2) @(negedge clk);
	check_pix = 1'b1;	// RAM settled from here on
	while (frame_cnt < f0 + n) @(negedge clk);
	check_pix = 1'b0;
endtask

// sync timing per frame and pixel compare against the model
always @(posedge clk) begin : raster_monitor
	int idx;
	logic px;
	if (rst_n) begin
		if (prev_vs && !vga_vsync) begin	// frame boundary
			if (frame_cnt > 0) begin
				assert (de_cnt == H_ACTIVE * V_ACTIVE) else begin
					err_sync++;
					$display("CHECK FAILED vga_de cycles: got %0h expected %0h",
						de_cnt, H_ACTIVE * V_ACTIVE);
				end
				assert (hs_pulses == V_TOTAL) else begin
					err_sync++;
					$display("CHECK FAILED vga_hsync pulses: got %0h expected %0h",
						hs_pulses, V_TOTAL);
				end
				assert (vs_low == V_SYNC * H_TOTAL) else begin
					err_sync++;
					$display("CHECK FAILED vga_vsync low cycles: got %0h expected %0h",
						vs_low, V_SYNC * H_TOTAL);
				end
			end
			de_cnt = 0;
			hs_pulses = 0;
			vs_low = 0;
			px_x = 0;
			px_y = 0;
			frame_cnt++;
		end
		if (!vga_vsync) vs_low++;
		if (prev_hs && !vga_hsync) hs_pulses++;
		if (!vga_hsync) hs_run++;
		if (!prev_hs && vga_hsync) begin
			assert (hs_run == H_SYNC) else begin
				err_sync++;
				$display("CHECK FAILED vga_hsync width: got %0h expected %0h", hs_run, H_SYNC);
			end
			hs_run = 0;
		end
		if (vga_de) begin
			de_cnt++;
			idx = px_y * BYTES_PER_LINE + px_x / 8;
			px = model[idx[7:0]][3'(7 - px_x % 8)];	// msb is the leftmost pixel
			if (check_pix) begin
				assert ({vga_r, vga_g, vga_b} == (px ? 16'hffff : 16'h0000)) else begin
					err_pix++;
					$display("CHECK FAILED {vga_r,vga_g,vga_b} at x %0d y %0d: got %h expected %h",
						px_x, px_y, {vga_r, vga_g, vga_b}, px ? 16'hffff : 16'h0000);
				end
			end
			if (px_x == H_ACTIVE - 1) begin
				px_x = 0;
				px_y++;
			end else begin
				px_x++;
			end
		end
		prev_hs = vga_hsync;
		prev_vs = vga_vsync;
	end
end

initial begin : stimulus
	int op_cnt;
	int wait_total;
	int p;
	logic [15:0] op;
	clk = 1'b0;
	rst_n = 1'b0;
	bus_addr = '0;
	bus_wdata = '0;
	bus_wr = 1'b0;
	bus_rd = 1'b0;
	lfsr = 32'hd8a8;
	err_data = 0;
	err_bus = 0;
	err_pix = 0;
	err_sync = 0;
	frame_cnt = 0;
	check_pix = 1'b0;
	prev_hs = 1'b1;
	prev_vs = 1'b1;
	hs_run = 0;
	hs_pulses = 0;
	vs_low = 0;
	de_cnt = 0;
	px_x = 0;
	px_y = 0;
	$readmemh("display_stim.mem", stim_mem);
	op_cnt = 0;
	wait_total = 0;
	p = 0;
	while (p < STIM_WORDS && stim_mem[p] != 16'h0000) begin
		case (stim_mem[p])
			16'h4: op_cnt += DISP_BYTES;
			16'h3: wait_total += int'(stim_mem[p + 2]);
			default: op_cnt++;
		endcase
		p += 4;
	end
	cycle_limit = op_cnt * 20 + (4 + wait_total) * FRAME_CYCLES;
	repeat (2) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;
	p = 0;
	while (p < STIM_WORDS && stim_mem[p] != 16'h0000) begin
		op = stim_mem[p];
		case (op)
			16'h1: bus_access(1'b1, stim_mem[p + 1], stim_mem[p + 2][7:0], 8'h00);
			16'h2: bus_access(1'b0, stim_mem[p + 1], 8'h00, stim_mem[p + 3][7:0]);
			16'h3: wait_frames(int'(stim_mem[p + 2]));
			16'h4: fill_window(stim_mem[p + 2][7:0]);
			default: begin
				err_bus++;
				$display("unknown opcode %h in the stimulus file", op);
			end
		endcase
		p += 4;
	end
	$display("errors: data %0d, bus %0d, pixel %0d, timing %0d",
		err_data, err_bus, err_pix, err_sync);
	if (err_data + err_bus + err_pix + err_sync == 0) begin
		$display("Simulation finished: PASS");
	end else begin
		$display("Simulation finished: FAIL");
	end
	$finish;
end

initial begin : watchdog
	int cycles;
	cycles = 0;
	wait (cycle_limit > 0);
	while (cycles < cycle_limit) begin
		@(posedge clk);
		cycles++;
	end
	$display("timeout, the run did not finish within %0d cycles", cycle_limit);
	$display("Simulation finished: FAIL");
	$finish;
end

endmodule

//--- display_stim.mem
// host operations, four hex words each: opcode address data expected
// opcode 1 write, 2 read, 3 wait frames (data = count), 4 fill window (data = seed), 0 end
04 0000 5a 00
03 0000 03 00
01 0200 a5 00
01 02ff 3c 00
01 0210 ff 00
01 0211 00 00
01 0280 81 00
02 0200 00 a5
02 02ff 00 3c
01 01ff 11 00
01 0300 22 00
01 0000 33 00
01 ffff 44 00
02 01ff 00 00
02 0300 00 00
02 0200 00 a5
02 02ff 00 3c
02 0210 00 ff
02 0211 00 00
02 0280 00 81
01 0230 12 00
01 0230 34 00
02 0230 00 34
01 0247 c3 00
01 02f8 0f 00
02 0247 00 c3
02 02f8 00 0f
02 0210 00 ff
03 0000 04 00
00 0000 00 00

//--- files.f
mk14_vdu_pkg.sv
disp_ram.sv
mem_arbiter.sv
host_port.sv
vdu_scanner.sv
mk14_display.sv
tb_mk14_display.sv

//--- Makefile
TOOL       = verilator
TOP        = tb_mk14_display
DUT        = mk14_display
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FLAGS      = --binary --timing --assert -Wno-fatal --timescale 1ns/10ps
LINT_FLAGS = --lint-only --timing -Wall --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(DUT) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
